// File: Makefile
VERILATOR	= verilator
FLAGS		= --binary --timing --assert -j 0
LINT_FLAGS	= --lint-only --timing --assert
TOP		= mgmt_tb
FLIST		= flist.f
OBJ_DIR		= obj_dir
PASS_MSG	= Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

# Build, run, and pass only when the pass line shows up in the output
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/apb_register_bank.sv
`timescale 1ns/1ns
`include "mgmt_config.svh"

module apb_register_bank (
	input  logic				clk,
	input  logic				reset,
	input  mgmt_pkg::apb_req_t	apb_req,
	output mgmt_pkg::apb_rsp_t	apb_rsp
);
	import mgmt_pkg::*;

	localparam int WORDS	= `MGMT_REG_WORDS;
	localparam int IDX_W	= $clog2(WORDS);

	reg_data_t			regs [WORDS];
	logic [IDX_W-1:0]	idx;
	logic				access;
	logic				wr_en;

	//////////////////////////////////////////////////////////////////////
	// Decode

	// Byte address to word index, wraps at the bank size
	assign idx		= apb_req.paddr[IDX_W:1];

	// Access phase of any transfer
	assign access	= apb_req.psel && apb_req.penable;

	// Word 0 is the identity and never takes a write
	assign wr_en	= access && apb_req.pwrite && (idx != '0);

	//////////////////////////////////////////////////////////////////////
	// Scratch registers

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < WORDS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			// Each lane follows its own strobe
			if (apb_req.pstrb[0]) begin
				regs[idx][7:0] <= apb_req.pwdata[7:0];
			end
			if (apb_req.pstrb[1]) begin
				regs[idx][15:8] <= apb_req.pwdata[15:8];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Response

	// Zero wait states, ready in the first access cycle
	always_comb begin
		apb_rsp.pready = access;
		if (idx == '0) begin
			apb_rsp.prdata = `MGMT_ID_VALUE;
		end else begin
			apb_rsp.prdata = regs[idx];
		end
	end

endmodule

// File: design/mgmt_bridge.sv
`timescale 1ns/1ns
`include "mgmt_config.svh"

module mgmt_bridge (
	input  logic					clk,
	input  logic					reset,
	input  logic					start,
	input  logic					stop,
	input  logic					insn_valid,
	input  mgmt_pkg::qspi_insn_t	insn,
	input  logic					wr_valid,
	input  mgmt_pkg::byte_t			wr_data,
	output logic					rd_mode,
	input  logic					rd_ready,
	output logic					rd_valid,
	output mgmt_pkg::byte_t			rd_data,
	output mgmt_pkg::apb_req_t		apb_req,
	input  mgmt_pkg::apb_rsp_t		apb_rsp
);
	import mgmt_pkg::*;

	logic			wr_mode;
	mgmt_addr_t		rd_addr;
	mgmt_addr_t		wr_addr;
	mgmt_addr_t		rd_addr_next;
	mgmt_addr_t		wr_addr_next;
	logic			rd_first;
	logic			wr_first;
	logic			wr_half;
	byte_t			wr_lo;
	mgmt_addr_t		wr_word_addr;
	byte_t			rd_hi;

	logic			rd_fire;
	logic			wr_fire;
	logic			rd_even;
	logic			rd_odd;
	logic			wr_even;
	logic			wr_odd;
	logic			wr_flush;
	logic			apb_done;
	logic			rd_done;

	//////////////////////////////////////////////////////////////////////
	// Byte stream decode

	assign rd_fire	= rd_ready && rd_mode;
	assign wr_fire	= wr_valid && wr_mode;

	// First byte uses the instruction address as is
	assign rd_addr_next	= rd_first ? rd_addr : rd_addr + 1'b1;
	assign wr_addr_next	= wr_first ? wr_addr : wr_addr + 1'b1;

	assign rd_even	= rd_fire && !rd_addr_next[0];
	assign rd_odd	= rd_fire && rd_addr_next[0];
	assign wr_even	= wr_fire && !wr_addr_next[0];
	assign wr_odd	= wr_fire && wr_addr_next[0];

	// Lone low byte left over when chip select rises
	assign wr_flush	= stop && wr_half;

	assign apb_done	= apb_req.psel && apb_req.penable && apb_rsp.pready;
	assign rd_done	= apb_done && !apb_req.pwrite;

	//////////////////////////////////////////////////////////////////////
	// Modes and address counters

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_mode		<= 1'b0;
			wr_mode		<= 1'b0;
			rd_first	<= 1'b0;
			wr_first	<= 1'b0;
			wr_half		<= 1'b0;
			rd_addr		<= '0;
			wr_addr		<= '0;
		end else begin
			if (start) begin
				rd_mode	<= 1'b0;
				wr_mode	<= 1'b0;
				wr_half	<= 1'b0;
			end else if (insn_valid) begin
				// Unknown opcodes leave both modes off
				rd_mode		<= (insn.opcode == `MGMT_OP_READ);
				wr_mode		<= (insn.opcode == `MGMT_OP_WRITE);
				rd_first	<= 1'b1;
				wr_first	<= 1'b1;
				rd_addr		<= insn.addr;
				wr_addr		<= insn.addr;
			end

			if (rd_fire) begin
				rd_first	<= 1'b0;
				rd_addr		<= rd_addr_next;
			end
			if (wr_fire) begin
				wr_first	<= 1'b0;
				wr_addr		<= wr_addr_next;
				wr_half		<= wr_even;
			end
			if (wr_flush) begin
				wr_half <= 1'b0;
			end
		end
	end

	// Low write byte and its word address wait for the pair
	always_ff @(posedge clk) begin
		if (wr_even) begin
			wr_lo			<= wr_data;
			wr_word_addr	<= wr_addr_next;
		end
		if (rd_done) begin
			rd_hi <= apb_rsp.prdata[15:8];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// APB requester

	always_ff @(posedge clk) begin
		if (reset) begin
			apb_req <= '0;
		end else begin
			// Setup then access, drop once the completer is ready
			if (apb_done) begin
				apb_req.psel	<= 1'b0;
				apb_req.penable	<= 1'b0;
			end else if (apb_req.psel) begin
				apb_req.penable	<= 1'b1;
			end

			if (rd_even) begin
				apb_req.psel	<= 1'b1;
				apb_req.penable	<= 1'b0;
				apb_req.pwrite	<= 1'b0;
				apb_req.paddr	<= rd_addr_next;
				apb_req.pstrb	<= 2'b11;
			end else if (wr_odd) begin
				apb_req.psel	<= 1'b1;
				apb_req.penable	<= 1'b0;
				apb_req.pwrite	<= 1'b1;
				apb_req.paddr	<= wr_word_addr;
				apb_req.pwdata	<= {wr_data, wr_lo};
				apb_req.pstrb	<= 2'b11;
			end else if (wr_flush) begin
				// Partial word, high byte untouched
				apb_req.psel	<= 1'b1;
				apb_req.penable	<= 1'b0;
				apb_req.pwrite	<= 1'b1;
				apb_req.paddr	<= wr_word_addr;
				apb_req.pwdata	<= {8'h00, wr_lo};
				apb_req.pstrb	<= 2'b01;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read data back to the front end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_done || rd_odd;
		end
	end

	// Even byte straight from the bus, odd byte from the kept half
	always_ff @(posedge clk) begin
		if (rd_done) begin
			rd_data <= apb_rsp.prdata[7:0];
		end else if (rd_odd) begin
			rd_data <= rd_hi;
		end
	end

	// Access phase always comes out of a setup phase
	assert property (@(posedge clk) disable iff (reset)
		apb_req.penable |-> (apb_req.psel && $past(apb_req.psel)))
		else $error("penable without a preceding psel");

	// Request fields hold from setup until the completer answers
	assert property (@(posedge clk) disable iff (reset)
		(apb_req.psel && !apb_done) |=> (apb_req.psel &&
		$stable({apb_req.pwrite, apb_req.paddr, apb_req.pwdata, apb_req.pstrb})))
		else $error("APB request changed before pready");

endmodule

// File: design/mgmt_config.svh
`ifndef MGMT_CONFIG_SVH
`define MGMT_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Management bridge build parameters

// Opcodes of the serial instruction
`define MGMT_OP_READ		8'h40
`define MGMT_OP_WRITE		8'h41

// Opcode byte plus three address bytes
`define MGMT_INSN_BYTES		4

// Register bank size in 16-bit words
`define MGMT_REG_WORDS		64

// Fixed contents of word 0
`define MGMT_ID_VALUE		16'h5A17

// Flops in each pin synchronizer
`define MGMT_SYNC_STAGES	2

`endif

// File: design/mgmt_pkg.sv
package mgmt_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths with a meaning

	// One byte of the serial stream
	typedef logic [7:0]		byte_t;

	// Byte address carried in the instruction
	typedef logic [23:0]	mgmt_addr_t;

	// APB data word and its byte strobes
	typedef logic [15:0]	reg_data_t;
	typedef logic [1:0]		reg_strb_t;

	//////////////////////////////////////////////////////////////////////
	// Bundles

	// Opcode first on the wire, so it sits in the top byte
	typedef struct packed {
		byte_t		opcode;
		mgmt_addr_t	addr;
	} qspi_insn_t;

	// Requester side of the APB link
	typedef struct packed {
		logic		psel;
		logic		penable;
		logic		pwrite;
		mgmt_addr_t	paddr;
		reg_data_t	pwdata;
		reg_strb_t	pstrb;
	} apb_req_t;

	// Completer side of the APB link
	typedef struct packed {
		logic		pready;
		reg_data_t	prdata;
	} apb_rsp_t;

	// QSPI front end FSM
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_INSN,
		ST_TURN,
		ST_DATA
	} qspi_state_t;

endpackage

// File: design/mgmt_top.sv
`timescale 1ns/1ns

module mgmt_top (
	input  logic		clk,
	input  logic		reset,
	input  logic		qspi_sck,
	input  logic		qspi_cs_n,
	input  logic [3:0]	qspi_dq_in,
	output logic [3:0]	qspi_dq_out,
	output logic		qspi_dq_oe
);
	import mgmt_pkg::*;

	// Front end to bridge
	logic			start;
	logic			stop;
	logic			insn_valid;
	qspi_insn_t		insn;
	logic			wr_valid;
	byte_t			wr_data;
	logic			rd_mode;
	logic			rd_ready;
	logic			rd_valid;
	byte_t			rd_data;

	// Bridge to register bank
	apb_req_t		apb_req;
	apb_rsp_t		apb_rsp;

	//////////////////////////////////////////////////////////////////////
	// Serial front end

	qspi_device_interface u_qspi (
		.clk		(clk),
		.reset		(reset),
		.sck		(qspi_sck),
		.cs_n		(qspi_cs_n),
		.dq_in		(qspi_dq_in),
		.dq_out		(qspi_dq_out),
		.dq_oe		(qspi_dq_oe),
		.start		(start),
		.stop		(stop),
		.insn_valid	(insn_valid),
		.insn		(insn),
		.wr_valid	(wr_valid),
		.wr_data	(wr_data),
		.rd_mode	(rd_mode),
		.rd_ready	(rd_ready),
		.rd_valid	(rd_valid),
		.rd_data	(rd_data)
	);

	//////////////////////////////////////////////////////////////////////
	// Byte stream to APB

	mgmt_bridge u_bridge (
		.clk		(clk),
		.reset		(reset),
		.start		(start),
		.stop		(stop),
		.insn_valid	(insn_valid),
		.insn		(insn),
		.wr_valid	(wr_valid),
		.wr_data	(wr_data),
		.rd_mode	(rd_mode),
		.rd_ready	(rd_ready),
		.rd_valid	(rd_valid),
		.rd_data	(rd_data),
		.apb_req	(apb_req),
		.apb_rsp	(apb_rsp)
	);

	// Stand-in for the chip's register space
	apb_register_bank u_regs (
		.clk		(clk),
		.reset		(reset),
		.apb_req	(apb_req),
		.apb_rsp	(apb_rsp)
	);

endmodule

// File: design/qspi_device_interface.sv
`timescale 1ns/1ns
`include "mgmt_config.svh"

module qspi_device_interface (
	input  logic					clk,
	input  logic					reset,
	input  logic					sck,
	input  logic					cs_n,
	input  logic [3:0]				dq_in,
	output logic [3:0]				dq_out,
	output logic					dq_oe,
	output logic					start,
	output logic					stop,
	output logic					insn_valid,
	output mgmt_pkg::qspi_insn_t	insn,
	output logic					wr_valid,
	output mgmt_pkg::byte_t			wr_data,
	input  logic					rd_mode,
	output logic					rd_ready,
	input  logic					rd_valid,
	input  mgmt_pkg::byte_t			rd_data
);
	import mgmt_pkg::*;

	localparam int SYNC			= `MGMT_SYNC_STAGES;
	localparam int INSN_CNT_W	= $clog2(`MGMT_INSN_BYTES);

	logic [SYNC-1:0]		sck_sync;
	logic [SYNC-1:0]		cs_sync;
	logic [3:0]				dq_sync [SYNC];
	logic					sck_prev;
	logic					cs_prev;
	logic					sck_rise;
	logic					sck_fall;
	logic					cs_rise;
	logic					cs_fall;
	logic [3:0]				dq_s;

	qspi_state_t			state;
	logic					nib_cnt;
	logic [INSN_CNT_W-1:0]	insn_cnt;
	logic [3:0]				nib_hold;
	byte_t					rx_byte;
	logic					byte_done;
	byte_t					tx_buf;
	byte_t					tx_shift;

	//////////////////////////////////////////////////////////////////////
	// Pin synchronizers and edge detection

	// Idle levels: sck low, chip select high
	always_ff @(posedge clk) begin
		if (reset) begin
			sck_sync	<= '0;
			cs_sync		<= '1;
			sck_prev	<= 1'b0;
			cs_prev		<= 1'b1;
		end else begin
			sck_sync	<= {sck_sync[SYNC-2:0], sck};
			cs_sync		<= {cs_sync[SYNC-2:0], cs_n};
			sck_prev	<= sck_sync[SYNC-1];
			cs_prev		<= cs_sync[SYNC-1];
		end
	end

	// Data lines take the same path, so they line up with sck
	always_ff @(posedge clk) begin
		dq_sync[0] <= dq_in;
		for (int i = 1; i < SYNC; i++) begin
			dq_sync[i] <= dq_sync[i-1];
		end
	end

	assign dq_s		= dq_sync[SYNC-1];
	assign sck_rise	= sck_sync[SYNC-1] && !sck_prev;
	assign sck_fall	= !sck_sync[SYNC-1] && sck_prev;
	assign cs_fall	= !cs_sync[SYNC-1] && cs_prev;
	assign cs_rise	= cs_sync[SYNC-1] && !cs_prev;

	// High nibble held, low nibble arriving now
	assign rx_byte		= {nib_hold, dq_s};
	assign byte_done	= sck_rise && nib_cnt && (state != ST_IDLE);

	//////////////////////////////////////////////////////////////////////
	// Frame FSM

	always_ff @(posedge clk) begin
		if (reset) begin
			state		<= ST_IDLE;
			nib_cnt		<= 1'b0;
			insn_cnt	<= '0;
			dq_oe		<= 1'b0;
			start		<= 1'b0;
			stop		<= 1'b0;
			insn_valid	<= 1'b0;
			wr_valid	<= 1'b0;
			rd_ready	<= 1'b0;
		end else begin
			// Strobes are single cycle
			start		<= 1'b0;
			stop		<= 1'b0;
			insn_valid	<= 1'b0;
			wr_valid	<= 1'b0;
			rd_ready	<= 1'b0;

			if (cs_fall) begin
				state		<= ST_INSN;
				nib_cnt		<= 1'b0;
				insn_cnt	<= '0;
				start		<= 1'b1;
			end else if (cs_rise) begin
				// Frame over, release the data lines
				state		<= ST_IDLE;
				dq_oe		<= 1'b0;
				stop		<= 1'b1;
			end else begin
				if (sck_rise && (state != ST_IDLE)) begin
					nib_cnt <= !nib_cnt;
				end

				case (state)
					ST_INSN: begin
						if (byte_done) begin
							insn_cnt <= insn_cnt + 1'b1;
							if (insn_cnt == INSN_CNT_W'(`MGMT_INSN_BYTES - 1)) begin
								insn_valid	<= 1'b1;
								state		<= ST_TURN;
							end
						end
					end
					ST_TURN: begin
						// rd_mode settles one cycle after insn_valid
						if (!insn_valid && !dq_oe) begin
							if (rd_mode) begin
								dq_oe		<= 1'b1;
								rd_ready	<= 1'b1;
							end else begin
								// Writes have no turnaround byte
								state		<= ST_DATA;
							end
						end
						// End of the dummy byte, first data byte begins
						if (byte_done && dq_oe) begin
							state		<= ST_DATA;
							rd_ready	<= 1'b1;
						end
					end
					ST_DATA: begin
						if (byte_done) begin
							if (rd_mode) begin
								rd_ready <= 1'b1;
							end else begin
								wr_valid <= 1'b1;
							end
						end
					end
					default: begin
					end
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Shift registers

	always_ff @(posedge clk) begin
		if (sck_rise && !nib_cnt) begin
			nib_hold <= dq_s;
		end

		// Instruction bytes shift in from the bottom
		if (byte_done && (state == ST_INSN)) begin
			insn <= {insn[$bits(qspi_insn_t)-9:0], rx_byte};
		end
		if (byte_done && (state == ST_DATA)) begin
			wr_data <= rx_byte;
		end

		// Prefetched byte waits here until its byte slot opens
		if (rd_valid) begin
			tx_buf <= rd_data;
		end

		// High nibble on the first falling edge, low on the second
		if (byte_done && dq_oe) begin
			tx_shift <= tx_buf;
		end else if (sck_fall && dq_oe && (state == ST_DATA)) begin
			dq_out		<= tx_shift[7:4];
			tx_shift	<= {tx_shift[3:0], 4'h0};
		end
	end

	// Instruction completes only from the instruction phase
	assert property (@(posedge clk) disable iff (reset)
		insn_valid |-> ($past(state) == ST_INSN))
		else $error("insn_valid outside the instruction phase");

endmodule

// File: flist.f
+incdir+design
design/mgmt_pkg.sv
design/qspi_device_interface.sv
design/mgmt_bridge.sv
design/apb_register_bank.sv
design/mgmt_top.sv
verification/mgmt_checker.sv
verification/mgmt_tb.sv

// File: verification/mgmt_checker.sv
`timescale 1ns/1ns

module mgmt_checker (
	input  logic	clk,
	input  logic	reset,
	input  logic	dq_oe
);
	import mgmt_pkg::*;

	string	test_name = "none";
	int		test_errors = 0;
	int		test_bytes = 0;
	int		tests_passed = 0;
	int		tests_failed = 0;

	// Set while a frame that must never drive the data lines is running
	logic	quiet = 1'b0;
	logic	oe_flagged = 1'b0;

	//////////////////////////////////////////////////////////////////////
	// Test bookkeeping

	task automatic begin_test(input string name);
		test_name	= name;
		test_errors	= 0;
		test_bytes	= 0;
	endtask

	// One read byte against the model
	task automatic compare_byte(input byte_t expected, input byte_t actual);
		test_bytes++;
		if (expected !== actual) begin
			test_errors++;
			$display("error %s expected %02h actual %02h", test_name, expected, actual);
		end
	endtask

	task automatic watch_output(input logic enable);
		quiet		= enable;
		oe_flagged	= 1'b0;
	endtask

	task automatic end_test();
		if (test_errors == 0) begin
			tests_passed++;
			$display("test %-12s pass, %0d bytes checked", test_name, test_bytes);
		end else begin
			tests_failed++;
			$display("test %-12s FAIL, %0d errors", test_name, test_errors);
		end
	endtask

	task automatic print_counts();
		$display("tests passed %0d, tests with errors %0d", tests_passed, tests_failed);
	endtask

	function automatic int failed_count();
		return tests_failed;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Output enable monitor

	// Mid-cycle sample, away from the clock edge
	always @(negedge clk) begin
		if (!reset && quiet && dq_oe && !oe_flagged) begin
			$display("test %s: DUT drove the data lines in a frame that returns no data",
				test_name);
			test_errors++;
			oe_flagged = 1'b1;
		end
	end

endmodule

// File: verification/mgmt_tb.sv
`timescale 1ns/1ns
`include "mgmt_config.svh"

module mgmt_tb;
	import mgmt_pkg::*;

	localparam int HALF			= 4;
	localparam int DRIVE_DELAY	= 10;
	localparam int FRAME_GAP	= 12;
	localparam int MAX_BURST	= 8;
	localparam int WORDS		= `MGMT_REG_WORDS;
	localparam int BURST_TESTS	= 4;
	localparam int ODD_TESTS	= 2;
	localparam int TEST_COUNT	= 3 + BURST_TESTS + ODD_TESTS;

	// Longest frame is 13 bytes
	// A test runs at most 3 frames
	localparam int FRAMES_PER_TEST	= 3;
	localparam int FRAME_CYCLES		= 13 * 2 * 8 + 40;
	localparam int CYCLE_LIMIT		= TEST_COUNT * FRAMES_PER_TEST * FRAME_CYCLES;

	logic		clk;
	logic		reset;
	logic		qspi_sck;
	logic		qspi_cs_n;
	logic [3:0]	qspi_dq_in;
	logic [3:0]	qspi_dq_out;
	logic		qspi_dq_oe;

	reg_data_t	model [WORDS];
	byte_t		wr_bytes [MAX_BURST];
	byte_t		rd_bytes [MAX_BURST];
	mgmt_addr_t	last_addr;
	int			last_len;
	int			cycle_count;
	logic		bank_write;
	int			writes_seen;

	mgmt_top UUT (
		.clk		(clk),
		.reset		(reset),
		.qspi_sck	(qspi_sck),
		.qspi_cs_n	(qspi_cs_n),
		.qspi_dq_in	(qspi_dq_in),
		.qspi_dq_out(qspi_dq_out),
		.qspi_dq_oe	(qspi_dq_oe)
	);

	mgmt_checker chk (
		.clk	(clk),
		.reset	(reset),
		.dq_oe	(qspi_dq_oe)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Register bank write strobe

	// Access phase of an APB write into the bank
	assign bank_write = UUT.apb_req.psel && UUT.apb_req.penable && UUT.apb_req.pwrite;

	always @(posedge clk) begin
		if (reset) begin
			writes_seen <= 0;
		end else if (bank_write) begin
			writes_seen <= writes_seen + 1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// QSPI host

	// Pins change just after the rising clock edge
	task automatic step(input int n);
		repeat (n) @(posedge clk);
		#DRIVE_DELAY;
	endtask

	// Mode 0 with data set while sck is low and sampled as sck rises
	task automatic shift_nibble(input logic [3:0] nib_out, output logic [3:0] nib_in);
		qspi_sck	= 1'b0;
		qspi_dq_in	= nib_out;
		step(HALF);
		qspi_sck	= 1'b1;
		nib_in		= qspi_dq_out;
		step(HALF);
	endtask

	task automatic send_byte(input byte_t b);
		logic [3:0] ignored;
		shift_nibble(b[7:4], ignored);
		shift_nibble(b[3:0], ignored);
	endtask

	// High nibble first
	task automatic recv_byte(output byte_t b);
		logic [3:0] hi;
		logic [3:0] lo;
		shift_nibble(4'h0, hi);
		shift_nibble(4'h0, lo);
		b = {hi, lo};
	endtask

	task automatic open_frame();
		qspi_cs_n = 1'b0;
		step(HALF);
	endtask

	// Last sck low, then chip select released
	task automatic close_frame();
		qspi_sck	= 1'b0;
		qspi_dq_in	= 4'h0;
		step(HALF);
		qspi_cs_n	= 1'b1;
	endtask

	task automatic send_insn(input byte_t op, input mgmt_addr_t addr);
		send_byte(op);
		send_byte(addr[23:16]);
		send_byte(addr[15:8]);
		send_byte(addr[7:0]);
	endtask

	// One bank write per byte pair plus one for a trailing lone byte
	task automatic write_frame(input byte_t op, input mgmt_addr_t addr, input int len);
		int target;
		target = writes_seen;
		if (op == `MGMT_OP_WRITE) begin
			target = target + (len + 1) / 2;
		end
		open_frame();
		send_insn(op, addr);
		for (int i = 0; i < len; i++) begin
			send_byte(wr_bytes[i]);
		end
		close_frame();
		// Frame is done once the bank has taken its last word
		while (writes_seen < target) begin
			step(1);
		end
		step(FRAME_GAP);
	endtask

	// One dummy byte of turnaround before the data
	task automatic read_frame(input mgmt_addr_t addr, input int len);
		byte_t b;
		open_frame();
		send_insn(`MGMT_OP_READ, addr);
		recv_byte(b);
		for (int i = 0; i < len; i++) begin
			recv_byte(b);
			rd_bytes[i] = b;
		end
		close_frame();
		step(FRAME_GAP);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Register model

	function automatic int word_index(input mgmt_addr_t a);
		return int'(a[23:1]) % WORDS;
	endfunction

	// Byte lane follows address parity and word 0 never changes
	task automatic model_write(input mgmt_addr_t addr, input int len);
		mgmt_addr_t	a;
		int			idx;
		for (int i = 0; i < len; i++) begin
			a	= addr + mgmt_addr_t'(i);
			idx	= word_index(a);
			if (idx != 0) begin
				if (a[0]) begin
					model[idx][15:8] = wr_bytes[i];
				end else begin
					model[idx][7:0] = wr_bytes[i];
				end
			end
		end
	endtask

	function automatic byte_t expected_byte(input mgmt_addr_t a);
		reg_data_t w;
		w = model[word_index(a)];
		return a[0] ? w[15:8] : w[7:0];
	endfunction

	task automatic check_read(input mgmt_addr_t addr, input int len);
		for (int i = 0; i < len; i++) begin
			chk.compare_byte(expected_byte(addr + mgmt_addr_t'(i)), rd_bytes[i]);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Random stimulus

	// Even start above word 0 with the whole burst inside the bank
	function automatic mgmt_addr_t random_addr(input int len);
		int top_word;
		int word;
		top_word	= (2 * WORDS - len) / 2;
		word		= 1 + int'($urandom % top_word);
		return mgmt_addr_t'(2 * word);
	endfunction

	function automatic int random_even_len();
		return 2 * (1 + int'($urandom % 4));
	endfunction

	task automatic fill_random(input int len);
		for (int i = 0; i < len; i++) begin
			wr_bytes[i] = byte_t'($urandom);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests

	task automatic read_identity();
		chk.begin_test("id_read");
		read_frame('0, 2);
		check_read('0, 2);
		chk.end_test();
	endtask

	task automatic write_read_burst(input int n);
		mgmt_addr_t	addr;
		int			len;
		len		= random_even_len();
		addr	= random_addr(len);
		fill_random(len);
		chk.begin_test($sformatf("burst_%0d", n));
		chk.watch_output(1'b1);
		write_frame(`MGMT_OP_WRITE, addr, len);
		chk.watch_output(1'b0);
		model_write(addr, len);
		read_frame(addr, len);
		check_read(addr, len);
		chk.end_test();
		last_addr	= addr;
		last_len	= len;
	endtask

	// Full pairs first and then an odd burst that leaves a lone low byte
	task automatic odd_length_write(input int n);
		mgmt_addr_t	addr;
		int			len;
		len		= 1 + 2 * int'($urandom % 4);
		addr	= random_addr(len + 1);
		chk.begin_test($sformatf("odd_write_%0d", n));
		chk.watch_output(1'b1);
		fill_random(len + 1);
		write_frame(`MGMT_OP_WRITE, addr, len + 1);
		model_write(addr, len + 1);
		fill_random(len);
		write_frame(`MGMT_OP_WRITE, addr, len);
		model_write(addr, len);
		chk.watch_output(1'b0);
		read_frame(addr, len + 1);
		check_read(addr, len + 1);
		chk.end_test();
	endtask

	task automatic write_identity();
		chk.begin_test("id_write");
		fill_random(2);
		chk.watch_output(1'b1);
		write_frame(`MGMT_OP_WRITE, '0, 2);
		chk.watch_output(1'b0);
		model_write('0, 2);
		read_frame('0, 2);
		check_read('0, 2);
		chk.end_test();
	endtask

	// Aimed at the last burst so the range holds known data
	task automatic unknown_opcode();
		byte_t op;
		op = byte_t'($urandom);
		while (op == `MGMT_OP_READ || op == `MGMT_OP_WRITE) begin
			op = byte_t'($urandom);
		end
		chk.begin_test("unknown_op");
		fill_random(last_len);
		chk.watch_output(1'b1);
		write_frame(op, last_addr, last_len);
		chk.watch_output(1'b0);
		read_frame(last_addr, last_len);
		check_read(last_addr, last_len);
		chk.end_test();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		void'($urandom(47));
		reset		= 1'b1;
		qspi_sck	= 1'b0;
		qspi_cs_n	= 1'b1;
		qspi_dq_in	= 4'h0;
		last_addr	= 24'h000002;
		last_len	= 2;
		for (int i = 0; i < WORDS; i++) begin
			model[i] = '0;
		end
		model[0] = `MGMT_ID_VALUE;

		repeat (3) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		step(4);

		read_identity();
		for (int i = 0; i < BURST_TESTS; i++) begin
			write_read_burst(i);
		end
		for (int i = 0; i < ODD_TESTS; i++) begin
			odd_length_write(i);
		end
		write_identity();
		unknown_opcode();

		chk.print_counts();
		if (chk.failed_count() == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Run limit from the test count and the longest frame
	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
		$display("Test failed");
		$finish;
	end

endmodule
